/* rtl/m68kCache_macros.svh */
// Shared widths and counts for the 68k set-associative read cache
`ifndef M68K_CACHE_MACROS_SVH
`define M68K_CACHE_MACROS_SVH

// CPU side bus widths
`define AddrWidth 32
`define DataWidth 16

// address split: tag | index | word select | byte
`define TagWidth 25
`define IndexWidth 3
`define WordSelWidth 3
`define OffsetWidth 4                   // byte offset inside one line of 16 bytes

// organisation of the store
`define NumWays 4
`define WayIndexWidth 2
`define NumSets 8                       // one set per index value
`define LineWords 8                     // 16-bit words in one line

// tree pseudo-LRU needs three bits for four ways
`define LruWidth 3

// the DRAM fills a whole line per read command
`define BurstLength `LineWords

`endif

/* rtl/m68kCachePkg.sv */
// Types shared by the cache blocks: bus bundles, store entries and FSM states
`default_nettype none

`include "m68kCache_macros.svh"

package m68kCachePkg;

	// what the 68k puts on the bus, strobes are active low as on the chip
	typedef struct packed {
		logic                   addressStrobe_L;
		logic                   dramSelect;           // address decoder says DRAM space
		logic                   write_L;
		logic                   upperStrobe_L;        // data bits 15 to 8
		logic                   lowerStrobe_L;        // data bits 7 to 0
		logic [`AddrWidth-1:0]  address;
		logic [`DataWidth-1:0]  writeData;
	} cpuReq_t;

	typedef struct packed {
		logic                   dtack_L;
		logic [`DataWidth-1:0]  readData;
	} cpuResp_t;

	// request towards the DRAM controller
	typedef struct packed {
		logic                   select_L;
		logic                   addressStrobe_L;
		logic                   write_L;
		logic                   upperStrobe_L;
		logic                   lowerStrobe_L;
		logic [`AddrWidth-1:0]  address;
		logic [`DataWidth-1:0]  writeData;
	} dramReq_t;

	// cas and ras are seen so that a read command can be told from a refresh
	typedef struct packed {
		logic                   dtack_L;
		logic                   cas_L;
		logic                   ras_L;
		logic [`DataWidth-1:0]  readData;
	} dramResp_t;

	typedef struct packed {
		logic                   valid;
		logic [`TagWidth-1:0]   tag;
	} tagEntry_t;

	typedef logic [`LruWidth-1:0]      lruBits_t;
	typedef logic [`NumWays-1:0]       wayMask_t;
	typedef logic [`WayIndexWidth-1:0] wayIndex_t;
	typedef logic [`IndexWidth-1:0]    setIndex_t;
	typedef logic [`WordSelWidth-1:0]  wordSel_t;

	typedef enum logic [3:0] {
		resetState,
		invalidate,
		idle,
		checkHit,
		holdHit,
		waitCas,
		casDelay1,
		casDelay2,
		burstFill,
		endFill,
		writeThrough
	} ctrlState_t;

	// lowest numbered way in a mask, way 0 when the mask is empty
	function automatic wayIndex_t firstWay(input wayMask_t ways);
		wayIndex_t way;
		way = '0;
		for (int w = `NumWays - 1; w >= 0; w--) begin
			if (ways[w])
				way = wayIndex_t'(w);
		end
		return way;
	endfunction

endpackage

`default_nettype wire

/* rtl/cacheSetArray.sv */
// Per-set store with one entry per way, used for the tags and for the LRU tree
`timescale 1ns/1ps
`default_nettype none

`include "m68kCache_macros.svh"

module cacheSetArray #(
	parameter type entryType = m68kCachePkg::tagEntry_t,
	parameter int  numWays   = `NumWays
) (
	input  logic                            Clock,
	input  logic                            Reset_L,
	input  m68kCachePkg::setIndex_t         index,          // set addressed for read and write
	input  logic [numWays-1:0]              writeEnable,    // one bit per way
	input  entryType                        writeData,      // same entry goes to every enabled way
	output entryType [numWays-1:0]          readData        // whole set, read without a clock
);

	// one row per set, each row holds every way of that set
	entryType [numWays-1:0] entries [`NumSets];

	//////////////////////////////////////////////////////////////////////
	// storage, cleared to zero on reset
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int s = 0; s < `NumSets; s++)
				entries[s] <= '0;                       // zero means invalid tag and a neutral LRU tree
		end else begin
			for (int w = 0; w < numWays; w++) begin
				if (writeEnable[w])
					entries[index][w] <= writeData;       // only the enabled ways of the set change
			end
		end
	end

	assign readData = entries[index];                   // the policy logic sees the set at once

	// the write enables come from the controller FSM, an X there would corrupt a whole set
	writeEnableKnown: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		!$isunknown(writeEnable)
	);

endmodule

`default_nettype wire

/* rtl/cacheDataArray.sv */
// Line data store, one word written per cycle, word of the hitting way read out
`timescale 1ns/1ps
`default_nettype none

`include "m68kCache_macros.svh"

module cacheDataArray (
	input  logic                            Clock,
	input  m68kCachePkg::setIndex_t         index,
	input  m68kCachePkg::wordSel_t          wordSel,        // word inside the line
	input  m68kCachePkg::wayMask_t          writeWay,       // at most one way during a fill
	input  logic [`DataWidth-1:0]           writeData,
	input  m68kCachePkg::wayMask_t          hitWays,        // picks the way that is read
	output logic [`DataWidth-1:0]           readData
);

	import m68kCachePkg::*;

	// set and word together address one word of a way
	logic [`DataWidth-1:0]                  wayWords [`NumWays][`NumSets * `LineWords];
	logic [`IndexWidth+`WordSelWidth-1:0]   wordAddr;
	wayIndex_t                              readWay;

	assign wordAddr = {index, wordSel};

	always_ff @(posedge Clock) begin
		for (int w = 0; w < `NumWays; w++) begin
			if (writeWay[w])
				wayWords[w][wordAddr] <= writeData;     // burst words land here one by one
		end
	end

	// with no hit this falls back to way 0, the FSM ignores the value then
	assign readWay  = firstWay(hitWays);
	assign readData = wayWords[readWay][wordAddr];

endmodule

`default_nettype wire

/* rtl/pLruPolicy.sv */
// Tag compare, hit detection and tree pseudo-LRU victim choice and update
`timescale 1ns/1ps
`default_nettype none

`include "m68kCache_macros.svh"

module pLruPolicy (
	input  m68kCachePkg::tagEntry_t [`NumWays-1:0] tags,     // all ways of the addressed set
	input  logic [`TagWidth-1:0]                   addressTag,
	input  m68kCachePkg::lruBits_t                 lruBits,
	output m68kCachePkg::wayMask_t                 hitWays,
	output logic                                   hit,
	output m68kCachePkg::wayIndex_t                victimWay,
	output m68kCachePkg::lruBits_t                 lruNext
);

	import m68kCachePkg::*;

	wayIndex_t touchedWay;

	// a way hits only when it holds a valid line with the same tag
	always_comb begin
		for (int w = 0; w < `NumWays; w++)
			hitWays[w] = tags[w].valid && (tags[w].tag == addressTag);
	end

	assign hit = |hitWays;

	// bit 0 chooses the half, bit 1 or bit 2 the way inside that half
	always_comb begin
		if (!lruBits[0])
			victimWay = lruBits[1] ? wayIndex_t'(1) : wayIndex_t'(0);
		else
			victimWay = lruBits[2] ? wayIndex_t'(3) : wayIndex_t'(2);
	end

	assign touchedWay = hit ? firstWay(hitWays) : victimWay;   // a miss touches the way it refills

	// the bits on the path to the touched way are turned to point away from it
	always_comb begin
		unique case (touchedWay)
			2'd0:    lruNext = {lruBits[2], 1'b1, 1'b1};
			2'd1:    lruNext = {lruBits[2], 1'b0, 1'b1};
			2'd2:    lruNext = {1'b1, lruBits[1], 1'b0};
			default: lruNext = {1'b0, lruBits[1], 1'b0};
		endcase
	end

endmodule

`default_nettype wire

/* rtl/cacheControlFsm.sv */
// Cache controller FSM: invalidation, hit service, burst line fill and write-through
`timescale 1ns/1ps
`default_nettype none

`include "m68kCache_macros.svh"

module cacheControlFsm (
	input  logic                        Clock,
	input  logic                        Reset_L,
	input  m68kCachePkg::cpuReq_t       cpuReq,
	input  m68kCachePkg::dramResp_t     dramResp,
	input  logic                        hit,
	input  m68kCachePkg::wayMask_t      hitWays,
	input  m68kCachePkg::wayIndex_t     victimWay,
	input  m68kCachePkg::lruBits_t      lruNext,
	output logic                        cpuDtack_L,
	output logic                        dramSelect_L,
	output logic                        readBurst,      // DRAM gets a line address with both strobes
	output m68kCachePkg::setIndex_t     setIndex,
	output m68kCachePkg::wordSel_t      wordSel,
	output m68kCachePkg::wayMask_t      tagWrite,
	output logic                        tagValid,
	output m68kCachePkg::wayMask_t      dataWrite,
	output logic                        lruWrite,
	output m68kCachePkg::lruBits_t      lruWriteData
);

	import m68kCachePkg::*;

	localparam logic [`WordSelWidth:0] lastSet  = `NumSets - 1;
	localparam logic [`WordSelWidth:0] lastFill = `BurstLength;

	ctrlState_t                 state, nextState;
	logic [`WordSelWidth:0]     burstCount;             // sets during invalidation, words during a fill
	logic                       counterClear;
	wayIndex_t                  victim_q;               // way being refilled
	logic                       loadVictim;
	wayMask_t                   victimMask;
	logic                       dtack_q;                // dtack for hits and fills, low active
	logic                       reqActive;
	logic                       readCommand;

	assign reqActive   = !cpuReq.addressStrobe_L && cpuReq.dramSelect;
	assign readCommand = !dramResp.cas_L && dramResp.ras_L;     // cas with ras also low is a refresh
	assign victimMask  = wayMask_t'(1) << victim_q;

	//////////////////////////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state      <= resetState;
			burstCount <= '0;
			victim_q   <= '0;
			dtack_q    <= 1'b1;
		end else begin
			state <= nextState;
			if (counterClear)
				burstCount <= '0;
			else
				burstCount <= burstCount + 1'b1;                // free running, only read where it matters
			if (loadVictim)
				victim_q <= victimWay;
			// dtack follows the state one edge late, so a hit answers two edges after idle
			dtack_q <= !(((state == holdHit) || (state == endFill)) && reqActive);
		end
	end

	// a write hands the DRAM's own dtack back to the CPU
	assign cpuDtack_L = (state == writeThrough) ? dramResp.dtack_L : dtack_q;

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState    = state;
		counterClear = 1'b0;
		loadVictim   = 1'b0;
		dramSelect_L = 1'b1;                                // the DRAM is left alone unless needed
		readBurst    = 1'b0;
		setIndex     = cpuReq.address[`OffsetWidth +: `IndexWidth];
		wordSel      = cpuReq.address[1 +: `WordSelWidth];
		tagWrite     = '0;
		tagValid     = 1'b0;
		dataWrite    = '0;
		lruWrite     = 1'b0;
		lruWriteData = lruNext;

		unique case (state)
			resetState: begin
				counterClear = 1'b1;                            // counter walks the sets next
				nextState    = invalidate;
			end
			invalidate: begin
				setIndex     = setIndex_t'(burstCount);
				tagWrite     = '1;                              // valid cleared in every way
				lruWrite     = 1'b1;
				lruWriteData = '0;
				if (burstCount == lastSet)
					nextState = idle;
			end
			idle: begin
				if (reqActive)
					nextState = cpuReq.write_L ? checkHit : writeThrough;
			end
			checkHit: begin
				readBurst = 1'b1;
				lruWrite  = 1'b1;                               // tree moves off the hit way or the victim
				if (hit) begin
					nextState = holdHit;
				end else begin
					loadVictim = 1'b1;
					nextState  = waitCas;
				end
			end
			holdHit: begin
				readBurst = 1'b1;
				if (!reqActive)
					nextState = idle;
			end
			waitCas: begin
				readBurst    = 1'b1;
				dramSelect_L = 1'b0;
				tagWrite     = victimMask;                      // claim the victim way for the new tag
				tagValid     = 1'b1;
				if (readCommand)
					nextState = casDelay1;
			end
			casDelay1: begin
				readBurst    = 1'b1;
				dramSelect_L = 1'b0;
				nextState    = casDelay2;
			end
			casDelay2: begin
				readBurst    = 1'b1;
				dramSelect_L = 1'b0;
				counterClear = 1'b1;
				nextState    = burstFill;
			end
			burstFill: begin
				readBurst    = 1'b1;
				dramSelect_L = 1'b0;
				// word k arrives while the count reads k+1, the first cycle carries nothing
				wordSel = wordSel_t'(burstCount - 1'b1);
				if (burstCount != '0)
					dataWrite = victimMask;
				if (burstCount == lastFill)
					nextState = endFill;
			end
			endFill: begin
				readBurst = 1'b1;                               // line is valid now, serve it like a hit
				if (!reqActive)
					nextState = idle;
			end
			writeThrough: begin
				dramSelect_L = 1'b0;
				tagWrite     = hitWays;                         // stale copies lose their valid bit
				if (!reqActive)
					nextState = idle;
			end
			default: nextState = resetState;
		endcase
	end

	// a fill writes one way at most, and only the way whose tag now claims the address
	dataWriteOneHot: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		$onehot0(dataWrite) && ((dataWrite & ~hitWays) == '0)
	);

	// the CPU must never see an acknowledge while nothing is being served
	noDtackInIdle: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		(state == idle) |-> cpuDtack_L
	);

endmodule

`default_nettype wire

/* rtl/m68kCacheTop.sv */
// Top of the 68k read cache, connecting controller, policy and stores to CPU and DRAM
`timescale 1ns/1ps
`default_nettype none

`include "m68kCache_macros.svh"

module m68kCacheTop (
	input  logic                        Clock,
	input  logic                        Reset_L,
	input  m68kCachePkg::cpuReq_t       cpuReq,
	output m68kCachePkg::cpuResp_t      cpuResp,
	output m68kCachePkg::dramReq_t      dramReq,
	input  m68kCachePkg::dramResp_t     dramResp
);

	import m68kCachePkg::*;

	tagEntry_t [`NumWays-1:0]   tagEntries;
	tagEntry_t                  tagWriteEntry;
	lruBits_t [0:0]             lruEntries;             // the tree is a single entry per set
	lruBits_t                   lruNext, lruWriteData;
	wayMask_t                   hitWays, tagWrite, dataWrite;
	wayIndex_t                  victimWay;
	setIndex_t                  setIndex;
	wordSel_t                   wordSel;
	logic                       hit, tagValid, lruWrite, readBurst, dramSelect_L, cpuDtack_L;
	logic [`TagWidth-1:0]       addressTag;
	logic [`DataWidth-1:0]      cacheReadData;

	assign addressTag    = cpuReq.address[`AddrWidth-1 -: `TagWidth];
	assign tagWriteEntry = '{valid: tagValid, tag: addressTag};
	assign cpuResp       = '{dtack_L: cpuDtack_L, readData: cacheReadData};

	//////////////////////////////////////////////////////////////////////
	// DRAM side, reads fetch the whole aligned line with both bytes
	//////////////////////////////////////////////////////////////////////
	assign dramReq.select_L        = dramSelect_L;
	assign dramReq.addressStrobe_L = cpuReq.addressStrobe_L;
	assign dramReq.write_L         = cpuReq.write_L;
	assign dramReq.upperStrobe_L   = readBurst ? 1'b0 : cpuReq.upperStrobe_L;
	assign dramReq.lowerStrobe_L   = readBurst ? 1'b0 : cpuReq.lowerStrobe_L;
	assign dramReq.address         = readBurst ?
		{cpuReq.address[`AddrWidth-1:`OffsetWidth], {`OffsetWidth{1'b0}}} : cpuReq.address;
	assign dramReq.writeData       = cpuReq.writeData;

	cacheControlFsm u_ctrl (
		.Clock, .Reset_L, .cpuReq, .dramResp,
		.hit, .hitWays, .victimWay, .lruNext,
		.cpuDtack_L, .dramSelect_L, .readBurst, .setIndex, .wordSel,
		.tagWrite, .tagValid, .dataWrite, .lruWrite, .lruWriteData
	);

	pLruPolicy u_policy (
		.tags(tagEntries), .addressTag, .lruBits(lruEntries[0]),
		.hitWays, .hit, .victimWay, .lruNext
	);

	cacheSetArray #(.entryType(tagEntry_t), .numWays(`NumWays)) tagStore (
		.Clock, .Reset_L, .index(setIndex), .writeEnable(tagWrite),
		.writeData(tagWriteEntry), .readData(tagEntries)
	);

	cacheSetArray #(.entryType(lruBits_t), .numWays(1)) lruStore (
		.Clock, .Reset_L, .index(setIndex), .writeEnable(lruWrite),
		.writeData(lruWriteData), .readData(lruEntries)
	);

	cacheDataArray u_data (
		.Clock, .index(setIndex), .wordSel, .writeWay(dataWrite),
		.writeData(dramResp.readData), .hitWays, .readData(cacheReadData)
	);

endmodule

`default_nettype wire

/* test/dramModel.sv */
// Behavioral DRAM controller with sparse memory, random latency, refresh commands and line bursts
`timescale 1ns/1ps
`default_nettype none

`include "m68kCache_macros.svh"

module dramModel (
	input  logic                        Clock,
	input  logic                        Reset_L,
	input  m68kCachePkg::dramReq_t      dramReq,
	output m68kCachePkg::dramResp_t     dramResp,
	output int                          refreshCount    // refresh commands sent since reset
);

	import m68kCachePkg::*;

	typedef enum logic [1:0] {modelIdle, modelDelay, modelBurst, modelRelease} modelState_t;

	logic [`DataWidth-1:0]  memory [logic [`AddrWidth-2:0]];   // only words that were written
	modelState_t            state;
	integer                 seed;
	int                     delayLeft;                  // idle cycles before the next command
	int                     refreshLeft;                // refreshes still to send before the read
	int                     beat;                       // cycles since the read command
	logic                   isWrite;
	logic [`AddrWidth-1:0]  lineAddr;

	initial seed = 32'he1313f63;

	// unwritten words show a pattern of the word address
	function automatic logic [`DataWidth-1:0] storedWord(input logic [`AddrWidth-1:0] byteAddr);
		if (memory.exists(byteAddr[`AddrWidth-1:1]))
			return memory[byteAddr[`AddrWidth-1:1]];
		return byteAddr[16:1] ^ 16'hA5C3;
	endfunction

	// byte merge as the strobes ask, a high strobe keeps the old byte
	task automatic storeWrite();
		logic [`DataWidth-1:0] merged;
		merged = storedWord(dramReq.address);
		if (!dramReq.upperStrobe_L)
			merged[15:8] = dramReq.writeData[15:8];
		if (!dramReq.lowerStrobe_L)
			merged[7:0] = dramReq.writeData[7:0];
		memory[dramReq.address[`AddrWidth-1:1]] = merged;
	endtask

	//////////////////////////////////////////////////////////////////////
	// command sequencer
	//////////////////////////////////////////////////////////////////////
	always @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state        <= modelIdle;
			dramResp     <= '{dtack_L: 1'b1, cas_L: 1'b1, ras_L: 1'b1, readData: '0};
			delayLeft    <= 0;
			refreshLeft  <= 0;
			beat         <= 0;
			isWrite      <= 1'b0;
			lineAddr     <= '0;
			refreshCount <= 0;
		end else begin
			dramResp.cas_L <= 1'b1;                         // every command lasts one cycle
			dramResp.ras_L <= 1'b1;
			case (state)
				modelIdle: begin
					if (!dramReq.select_L) begin
						isWrite     <= !dramReq.write_L;
						delayLeft   <= {$random(seed)} % 4;
						refreshLeft <= dramReq.write_L ? ({$random(seed)} % 3) : 0;   // reads only
						state       <= modelDelay;
					end
				end
				modelDelay: begin
					if (delayLeft > 0) begin
						delayLeft <= delayLeft - 1;
					end else if (refreshLeft > 0) begin
						// cas and ras both low, the cache has to let this one pass
						dramResp.cas_L <= 1'b0;
						dramResp.ras_L <= 1'b0;
						refreshLeft    <= refreshLeft - 1;
						refreshCount   <= refreshCount + 1;
						delayLeft      <= {$random(seed)} % 2;
					end else if (isWrite) begin
						storeWrite();
						dramResp.dtack_L <= 1'b0;               // held until the select goes away
						state            <= modelRelease;
					end else begin
						dramResp.cas_L <= 1'b0;                 // read command, ras stays high
						lineAddr       <= dramReq.address;
						beat           <= 0;
						state          <= modelBurst;
					end
				end
				modelBurst: begin
					beat <= beat + 1;
					// word k sits on the bus k+3 edges after the edge that sees the command
					if (beat >= 3 && beat <= 10)
						dramResp.readData <= storedWord(lineAddr + 32'(2 * (beat - 3)));
					if (beat == 10)
						state <= modelRelease;
				end
				default: begin
					if (dramReq.select_L) begin
						dramResp.dtack_L <= 1'b1;
						state            <= modelIdle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* test/m68kCacheTb.sv */
// Testbench for the 68k read cache, replaying CPU accesses from a case file against a DRAM model
`timescale 1ns/1ps
`default_nettype none

`include "m68kCache_macros.svh"

module m68kCacheTb;

	import m68kCachePkg::*;

	// one access of the case file
	typedef struct packed {
		logic                   isWrite;
		logic [`AddrWidth-1:0]  address;
		logic [1:0]             strobes_L;          // upper then lower, active low
		logic [`DataWidth-1:0]  writeData;
		logic [`DataWidth-1:0]  expectData;
		logic                   expectSelect;       // the DRAM must be selected during the access
	} accessCase_t;

	localparam int cyclesPerCase = 200;
	localparam int hitLatency    = 4;                   // falling edges from request to dtack on a hit
	localparam int releaseDelay  = 2;                   // falling edges from withdraw to dtack high

	logic           Clock;
	logic           Reset_L;
	cpuReq_t        cpuReq;
	cpuResp_t       cpuResp;
	dramReq_t       dramReq;
	dramResp_t      dramResp;
	int             refreshCount;
	accessCase_t    cases [$];
	logic           casesLoaded;
	int             currentCase;

	m68kCacheTop u_dut (.Clock, .Reset_L, .cpuReq, .cpuResp, .dramReq, .dramResp);

	dramModel u_dram (.Clock, .Reset_L, .dramReq, .dramResp, .refreshCount);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	//////////////////////////////////////////////////////////////////////
	// checking and case file
	//////////////////////////////////////////////////////////////////////
	task automatic compareValue(input string signalName, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] time %0t case %0d: %s is %h, expected %h",
				$time, currentCase, signalName, actual, expected);
			$display("Testbench failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic loadCases();
		int                     fd;
		int                     fields;
		int                     selectFlag;
		string                  line;
		logic [7:0]             opChar;
		logic [`AddrWidth-1:0]  address;
		logic [1:0]             strobes;
		logic [`DataWidth-1:0]  writeData;
		logic [`DataWidth-1:0]  expectData;
		accessCase_t            entry;
		fd = $fopen("test/cacheCases.txt", "r");
		if (fd == 0) begin
			$display("[ERROR] the case file test/cacheCases.txt could not be opened");
			$display("Testbench failed");
			$fatal(1, "no stimulus");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;                                   // column notes and blank lines
			fields = $sscanf(line, "%c %h %b %h %h %d",
				opChar, address, strobes, writeData, expectData, selectFlag);
			if (fields != 6 || (opChar != "R" && opChar != "W")) begin
				$display("[ERROR] the case file holds a line that cannot be read: %s", line);
				$display("Testbench failed");
				$fatal(1, "bad case file");
			end
			entry.isWrite      = (opChar == "W");
			entry.address      = address;
			entry.strobes_L    = strobes;
			entry.writeData    = writeData;
			entry.expectData   = expectData;
			entry.expectSelect = (selectFlag != 0);
			cases.push_back(entry);
		end
		$fclose(fd);
	endtask

	// what the DRAM must see while it is selected
	task automatic checkDramRequest(input accessCase_t c);
		// the CPU holds its strobe for the whole access and the DRAM sees it too
		compareValue("dramReq.addressStrobe_L", 32'(dramReq.addressStrobe_L), 32'd0);
		if (c.isWrite) begin
			compareValue("dramReq.address", dramReq.address, c.address);
			compareValue("dramReq.upperStrobe_L", 32'(dramReq.upperStrobe_L), 32'(c.strobes_L[1]));
			compareValue("dramReq.lowerStrobe_L", 32'(dramReq.lowerStrobe_L), 32'(c.strobes_L[0]));
			compareValue("dramReq.writeData", 32'(dramReq.writeData), 32'(c.writeData));
			compareValue("dramReq.write_L", 32'(dramReq.write_L), 32'd0);
		end else begin
			// a fill asks for the aligned line with both bytes
			compareValue("dramReq.address", dramReq.address, {c.address[31:4], 4'h0});
			compareValue("dramReq.upperStrobe_L", 32'(dramReq.upperStrobe_L), 32'd0);
			compareValue("dramReq.lowerStrobe_L", 32'(dramReq.lowerStrobe_L), 32'd0);
			compareValue("dramReq.write_L", 32'(dramReq.write_L), 32'd1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one 68k bus cycle
	//////////////////////////////////////////////////////////////////////
	task automatic runCase(input accessCase_t c);
		int                     waitCycles;
		int                     releaseCycles;
		logic                   selectSeen;
		logic [`DataWidth-1:0]  readValue;
		waitCycles    = 0;
		releaseCycles = 0;
		selectSeen    = 1'b0;
		@(posedge Clock);
		cpuReq <= '{addressStrobe_L: 1'b0, dramSelect: 1'b1, write_L: !c.isWrite,
			upperStrobe_L: c.strobes_L[1], lowerStrobe_L: c.strobes_L[0],
			address: c.address, writeData: c.writeData};
		// outputs are looked at on the falling edge, half a cycle clear of any update
		do begin
			@(negedge Clock);
			waitCycles++;
			if (!dramReq.select_L) begin
				selectSeen = 1'b1;
				checkDramRequest(c);
			end
		end while (cpuResp.dtack_L);
		readValue = cpuResp.readData;                       // valid while dtack is low
		compareValue("dramReq.select_L seen", 32'(selectSeen), 32'(c.expectSelect));
		if (!c.isWrite) begin
			compareValue("cpuResp.readData", 32'(readValue), 32'(c.expectData));
			if (!c.expectSelect)
				compareValue("dtack_L hit latency", waitCycles, hitLatency);
		end
		@(posedge Clock);
		cpuReq.addressStrobe_L <= 1'b1;                     // end of the bus cycle
		do begin
			@(negedge Clock);
			releaseCycles++;
		end while (!cpuResp.dtack_L);
		compareValue("dtack_L release", releaseCycles, releaseDelay);
		repeat (2) @(posedge Clock);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		Reset_L     = 1'b0;
		cpuReq      = '{addressStrobe_L: 1'b1, dramSelect: 1'b0, write_L: 1'b1,
			upperStrobe_L: 1'b1, lowerStrobe_L: 1'b1, address: '0, writeData: '0};
		casesLoaded = 1'b0;
		currentCase = 0;
		loadCases();
		casesLoaded = 1'b1;
		repeat (3) @(posedge Clock);
		Reset_L <= 1'b1;
		foreach (cases[i]) begin
			currentCase = i + 1;
			runCase(cases[i]);
		end
		if (refreshCount == 0) begin
			$display("[ERROR] the DRAM model never sent a refresh ahead of a read command");
			$display("Testbench failed");
			$fatal(1, "refresh path not exercised");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

	// the budget grows with the number of cases
	initial begin : watchdog
		wait (casesLoaded);
		repeat (cases.size() * cyclesPerCase + 10) @(posedge Clock);
		$display("[ERROR] the run took longer than %0d cycles per case, a handshake hung",
			cyclesPerCase);
		$display("Testbench failed");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* test/cacheCases.txt */
# op address strobes(upper,lower active low) writeData expectData expectSelect
# op is R or W, data in hex, expectData unused for writes, expectSelect 1 means a DRAM access
R 00000000 00 0000 A5C3 1
R 00000006 00 0000 A5C0 0
R 0000000E 00 0000 A5C4 0
R 00000012 00 0000 A5CA 1
R 0000001C 00 0000 A5CD 0
R 00012344 00 0000 3461 1
R 0001234A 00 0000 3466 0
R 00000002 00 0000 A5C2 0
R 00000030 00 0000 A5DB 1
W 00000032 01 7E11 0000 1
R 00000032 00 0000 7EDA 1
R 00000030 00 0000 A5DB 0
W 00000448 10 00BE 0000 1
R 00000448 00 0000 A7BE 1
R 0001234A 00 0000 3466 0
W 00000004 00 1234 0000 1
R 00000004 00 0000 1234 1
R 00000000 00 0000 A5C3 0
R 00001050 00 0000 ADEB 1
R 00002052 00 0000 B5EA 1
R 00003054 00 0000 BDE9 1
R 00004056 00 0000 85E8 1
R 00005058 00 0000 8DEF 1
R 0000205E 00 0000 B5EC 0
R 00003050 00 0000 BDEB 0
R 0000405A 00 0000 85EE 0
R 00005050 00 0000 8DEB 0
R 00001050 00 0000 ADEB 1
R 00002050 00 0000 B5EB 1
R 00004050 00 0000 85EB 0

/* filelist.f */
+incdir+rtl
rtl/m68kCachePkg.sv
rtl/cacheSetArray.sv
rtl/cacheDataArray.sv
rtl/pLruPolicy.sv
rtl/cacheControlFsm.sv
rtl/m68kCacheTop.sv
test/dramModel.sv
test/m68kCacheTb.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module m68kCacheTb -f filelist.f -o m68kCacheSim

run: compile
	./obj_dir/m68kCacheSim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
